//--- source/dcache_consts.svh
// Data Cache Constants
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// word and address geometry
`define DC_WORD_SIZE        4                    // bytes per word
`define DC_DATA_WIDTH       32                   // bits per word
`define DC_ADDR_WIDTH       32                   // address bits

// cache geometry
`define DC_CACHE_SIZE       1024                 // bytes
`define DC_LINE_SIZE        16                   // bytes per line
`define DC_LINE_WIDTH       128                  // bits per line
`define DC_NUM_LINES        64                   // direct-mapped, one line per index

// address field widths, tag | index | offset from high to low
`define DC_OFFSET_WIDTH     4                    // log2 of line size
`define DC_INDEX_WIDTH      6                    // log2 of line count
`define DC_TAG_WIDTH        22                   // remaining upper bits

// word number within a line, upper offset bits
`define DC_WORD_SEL_WIDTH   2

`endif

//--- source/dcache_pkg.sv
// Data Cache Types
`default_nettype none

package dcache_pkg;

`include "dcache_consts.svh"

    typedef logic [`DC_DATA_WIDTH-1:0] dc_data_t;       // one data word
    typedef logic [`DC_LINE_WIDTH-1:0] dc_line_t;       // one full cache line
    typedef logic [`DC_WORD_SIZE-1:0]  dc_byte_sel_t;   // one enable per byte

    // an address is seen either as a plain word or split into cache fields
    typedef union packed {
        logic [`DC_ADDR_WIDTH-1:0] raw;
        struct packed {
            logic [`DC_TAG_WIDTH-1:0]    tag;
            logic [`DC_INDEX_WIDTH-1:0]  index;
            logic [`DC_OFFSET_WIDTH-1:0] offset;
        } fields;
    } dc_addr_u;

endpackage

`default_nettype wire

//--- source/dcache_req_stage.sv
// Cache Request Stage
`default_nettype none

`include "dcache_consts.svh"

module dcache_req_stage
    import dcache_pkg::*;
(
    input  logic                          clk,
    input  logic                          i_rst,

    input  logic                          i_re,
    input  logic                          i_we,
    input  logic                          i_fe,
    input  dc_addr_u                      i_addr,
    input  dc_line_t                      i_data,
    input  dc_byte_sel_t                  i_byte_sel,
    input  logic                          i_fill_dirty,

    output logic                          o_re,
    output logic                          o_we,
    output logic                          o_fe,
    output logic [`DC_TAG_WIDTH-1:0]      o_tag,
    output logic [`DC_INDEX_WIDTH-1:0]    o_index,
    output logic [`DC_WORD_SEL_WIDTH-1:0] o_word_sel,
    output dc_line_t                      o_data,
    output dc_byte_sel_t                  o_byte_sel,
    output logic                          o_fill_dirty
);

    logic [`DC_TAG_WIDTH-1:0]      req_tag;
    logic [`DC_INDEX_WIDTH-1:0]    req_index;
    logic [`DC_WORD_SEL_WIDTH-1:0] req_word_sel;

    // split the address through the field view of the union
    // byte offset within the word is dropped, accesses are word aligned
    assign req_tag      = i_addr.fields.tag;
    assign req_index    = i_addr.fields.index;
    assign req_word_sel = i_addr.fields.offset[`DC_OFFSET_WIDTH-1 -: `DC_WORD_SEL_WIDTH];

    // strobes are control state and clear on reset
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_re <= 1'b0;
            o_we <= 1'b0;
            o_fe <= 1'b0;
        end else begin
            o_re <= i_re;
            o_we <= i_we;
            o_fe <= i_fe;
        end
    end

    // payload follows the strobes, qualified downstream
    always_ff @(posedge clk) begin
        o_tag        <= req_tag;
        o_index      <= req_index;
        o_word_sel   <= req_word_sel;
        o_data       <= i_data;         // full line for fills, low word for stores
        o_byte_sel   <= i_byte_sel;
        o_fill_dirty <= i_fill_dirty;
    end

endmodule

`default_nettype wire

//--- source/dcache_array_stage.sv
// Cache Array Stage
`default_nettype none

`include "dcache_consts.svh"

module dcache_array_stage
    import dcache_pkg::*;
(
    input  logic                          clk,
    input  logic                          i_rst,

    input  logic                          i_re,
    input  logic                          i_we,
    input  logic                          i_fe,
    input  logic [`DC_TAG_WIDTH-1:0]      i_tag,
    input  logic [`DC_INDEX_WIDTH-1:0]    i_index,
    input  logic [`DC_WORD_SEL_WIDTH-1:0] i_word_sel,
    input  dc_line_t                      i_data,
    input  dc_byte_sel_t                  i_byte_sel,
    input  logic                          i_fill_dirty,

    output logic                          o_valid,
    output logic                          o_hit,
    output dc_data_t                      o_data,
    output logic                          o_victim_valid,
    output dc_addr_u                      o_victim_addr,
    output dc_line_t                      o_victim_data
);

    // storage, one entry per index
    logic [`DC_TAG_WIDTH-1:0] tag_mem  [`DC_NUM_LINES];
    dc_line_t                 line_mem [`DC_NUM_LINES];
    logic [`DC_NUM_LINES-1:0] valid_q;
    logic [`DC_NUM_LINES-1:0] dirty_q;

    // lookup of the addressed entry
    logic [`DC_TAG_WIDTH-1:0] old_tag;
    dc_line_t                 old_line;
    logic                     old_valid;
    logic                     old_dirty;
    logic                     tag_match;
    dc_data_t                 old_word;

    // update path
    dc_data_t                 store_word;
    dc_data_t                 merged_word;
    dc_line_t                 store_line;
    dc_line_t                 new_line;
    dc_data_t                 fill_word;
    logic                     store_hit;
    logic                     line_wr_en;

    // response
    logic                     resp_hit;
    dc_data_t                 resp_data;
    logic                     victim;
    dc_addr_u                 victim_addr;

    assign old_tag    = tag_mem[i_index];
    assign old_line   = line_mem[i_index];
    assign old_valid  = valid_q[i_index];
    assign old_dirty  = dirty_q[i_index];
    assign tag_match  = old_valid && (old_tag == i_tag);
    assign old_word   = old_line[i_word_sel*`DC_DATA_WIDTH +: `DC_DATA_WIDTH];

    assign store_word = i_data[`DC_DATA_WIDTH-1:0];   // stores carry data in the low word
    assign fill_word  = i_data[i_word_sel*`DC_DATA_WIDTH +: `DC_DATA_WIDTH];

    // byte merge of store data over the current word
    always_comb begin
        for (int b = 0; b < `DC_WORD_SIZE; b++) begin
            merged_word[b*8 +: 8] = i_byte_sel[b] ? store_word[b*8 +: 8] : old_word[b*8 +: 8];
        end
    end

    // old line with the merged word put back in place
    always_comb begin
        store_line = old_line;
        store_line[i_word_sel*`DC_DATA_WIDTH +: `DC_DATA_WIDTH] = merged_word;
    end

    assign store_hit  = i_we && tag_match;            // store misses leave the line alone
    assign line_wr_en = i_fe || store_hit;
    assign new_line   = i_fe ? i_data : store_line;

    // a fill always hits, reads and stores need a valid matching tag
    assign resp_hit   = i_fe || tag_match;

    // fill returns the new word, store returns the merged word
    always_comb begin
        if (i_fe) begin
            resp_data = fill_word;
        end else if (i_we) begin
            resp_data = merged_word;
        end else begin
            resp_data = old_word;
        end
    end

    // write-back needed only when a different dirty line gets evicted
    assign victim = i_fe && old_valid && old_dirty && (old_tag != i_tag);

    // victim line address, offset cleared
    always_comb begin
        victim_addr.fields.tag    = old_tag;
        victim_addr.fields.index  = i_index;
        victim_addr.fields.offset = '0;
    end

    // tag and data arrays, written at the same edge as the response
    always_ff @(posedge clk) begin
        if (line_wr_en) begin
            tag_mem[i_index]  <= i_tag;
            line_mem[i_index] <= new_line;
        end
    end

    // line state bits
    always_ff @(posedge clk) begin
        if (i_rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (i_fe) begin
            valid_q[i_index] <= 1'b1;
            dirty_q[i_index] <= i_fill_dirty;
        end else if (store_hit) begin
            dirty_q[i_index] <= 1'b1;
        end
    end

    // response strobes
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_valid        <= 1'b0;
            o_victim_valid <= 1'b0;
        end else begin
            o_valid        <= i_re || i_we || i_fe;
            o_victim_valid <= victim;
        end
    end

    // response payload, sampled by the caller while o_valid is high
    always_ff @(posedge clk) begin
        o_hit         <= resp_hit;
        o_data        <= resp_data;
        o_victim_addr <= victim_addr;
        o_victim_data <= old_line;                    // line contents before this fill
    end

endmodule

`default_nettype wire

//--- source/dcache.sv
// Data Cache
`default_nettype none

`include "dcache_consts.svh"

module dcache
    import dcache_pkg::*;
(
    input  logic         clk,
    input  logic         i_rst,

    input  logic         i_dc_re,
    input  logic         i_dc_we,
    input  logic         i_dc_fe,
    input  dc_addr_u     i_dc_addr,
    input  dc_line_t     i_dc_data,
    input  dc_byte_sel_t i_dc_byte_select,
    input  logic         i_dc_fill_dirty,

    output logic         o_dc_valid,
    output logic         o_dc_hit,
    output dc_data_t     o_dc_data,
    output logic         o_dc_victim_valid,
    output dc_addr_u     o_dc_victim_addr,
    output dc_line_t     o_dc_victim_data
);

    // request registered and split in stage 1
    logic                          s1_re;
    logic                          s1_we;
    logic                          s1_fe;
    logic [`DC_TAG_WIDTH-1:0]      s1_tag;
    logic [`DC_INDEX_WIDTH-1:0]    s1_index;
    logic [`DC_WORD_SEL_WIDTH-1:0] s1_word_sel;
    dc_line_t                      s1_data;
    dc_byte_sel_t                  s1_byte_sel;
    logic                          s1_fill_dirty;

    dcache_req_stage req_stage_i (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_re         (i_dc_re),
        .i_we         (i_dc_we),
        .i_fe         (i_dc_fe),
        .i_addr       (i_dc_addr),
        .i_data       (i_dc_data),
        .i_byte_sel   (i_dc_byte_select),
        .i_fill_dirty (i_dc_fill_dirty),
        .o_re         (s1_re),
        .o_we         (s1_we),
        .o_fe         (s1_fe),
        .o_tag        (s1_tag),
        .o_index      (s1_index),
        .o_word_sel   (s1_word_sel),
        .o_data       (s1_data),
        .o_byte_sel   (s1_byte_sel),
        .o_fill_dirty (s1_fill_dirty)
    );

    dcache_array_stage array_stage_i (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_re           (s1_re),
        .i_we           (s1_we),
        .i_fe           (s1_fe),
        .i_tag          (s1_tag),
        .i_index        (s1_index),
        .i_word_sel     (s1_word_sel),
        .i_data         (s1_data),
        .i_byte_sel     (s1_byte_sel),
        .i_fill_dirty   (s1_fill_dirty),
        .o_valid        (o_dc_valid),
        .o_hit          (o_dc_hit),
        .o_data         (o_dc_data),
        .o_victim_valid (o_dc_victim_valid),
        .o_victim_addr  (o_dc_victim_addr),
        .o_victim_data  (o_dc_victim_data)
    );

endmodule

`default_nettype wire

//--- tb/dcache_tb.sv
// Data Cache Testbench
`default_nettype none

`include "dcache_consts.svh"

module dcache_tb
    import dcache_pkg::*;
();

    localparam int EXP_W      = 194;              // hit, word, victim flag, victim addr, victim line
    localparam int CLK_PERIOD = 4;
    localparam int LATENCY    = 2;                // cycles from request sample to response

    logic         clk;
    logic         i_rst;
    logic         i_dc_re;
    logic         i_dc_we;
    logic         i_dc_fe;
    dc_addr_u     i_dc_addr;
    dc_line_t     i_dc_data;
    dc_byte_sel_t i_dc_byte_select;
    logic         i_dc_fill_dirty;
    logic         o_dc_valid;
    logic         o_dc_hit;
    dc_data_t     o_dc_data;
    logic         o_dc_victim_valid;
    dc_addr_u     o_dc_victim_addr;
    dc_line_t     o_dc_victim_data;

    // model of the cache contents
    logic [`DC_TAG_WIDTH-1:0] m_tag   [`DC_NUM_LINES];
    dc_line_t                 m_line  [`DC_NUM_LINES];
    logic                     m_valid [`DC_NUM_LINES];
    logic                     m_dirty [`DC_NUM_LINES];

    logic [EXP_W-1:0] expect_q[$];                // one entry per request in flight
    time              accept_q[$];                // edge at which the DUT took each request

    dcache dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [EXP_W-1:0] dcache_model_step(input logic we, input logic fe,
            input dc_addr_u a, input dc_line_t d, input dc_byte_sel_t bs, input logic fd);
        logic [`DC_INDEX_WIDTH-1:0] idx;
        logic [`DC_TAG_WIDTH-1:0]   tg;
        int                         w;
        logic                       hit;
        dc_data_t                   word;
        logic                       vv;
        dc_addr_u                   va;
        dc_line_t                   vd;
        dc_line_t                   line;
        idx  = a.fields.index;
        tg   = a.fields.tag;
        w    = int'(a.fields.offset[3:2]);     // word number in the line
        line = m_line[idx];
        hit  = m_valid[idx] && (m_tag[idx] == tg);
        word = line[w*32 +: 32];
        vv     = 1'b0;
        va.raw = '0;
        vd     = '0;
        if (fe) begin
            // only a dirty line of another tag needs writing back
            if (m_valid[idx] && m_dirty[idx] && (m_tag[idx] != tg)) begin
                vv     = 1'b1;
                va.raw = {m_tag[idx], idx, 4'h0};
                vd     = line;
            end
            hit          = 1'b1;
            word         = d[w*32 +: 32];
            m_tag[idx]   = tg;
            m_line[idx]  = d;
            m_valid[idx] = 1'b1;
            m_dirty[idx] = fd;
        end else if (we && hit) begin
            for (int b = 0; b < `DC_WORD_SIZE; b++) begin
                if (bs[b]) word[b*8 +: 8] = d[b*8 +: 8];
            end
            line[w*32 +: 32] = word;
            m_line[idx]      = line;
            m_dirty[idx]     = 1'b1;
        end
        return {hit, word, vv, va.raw, vd};
    endfunction

    task automatic check_value(input string name, input logic [127:0] exp_v,
            input logic [127:0] act_v);
        if (exp_v !== act_v) begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
            $display("Some tests failed");
            $fatal(1, "output check failed");
        end
    endtask

    // compare each response with the oldest expectation
    always @(posedge clk) begin
        logic [EXP_W-1:0] e;
        time              t_acc;
        if (o_dc_valid) begin
            if (expect_q.size() == 0) begin
                $display("Response at %0t arrived with no request outstanding", $time);
                $display("Some tests failed");
                $fatal(1, "unexpected response");
            end else begin
                e     = expect_q.pop_front();
                t_acc = accept_q.pop_front();
                check_value("o_dc_valid", LATENCY, ($time - t_acc) / CLK_PERIOD);
                check_value("o_dc_hit", e[193], o_dc_hit);
                if (e[193]) check_value("o_dc_data", e[192:161], o_dc_data);
                check_value("o_dc_victim_valid", e[160], o_dc_victim_valid);
                if (e[160]) begin
                    check_value("o_dc_victim_addr", e[159:128], o_dc_victim_addr.raw);
                    check_value("o_dc_victim_data", e[127:0], o_dc_victim_data);
                end
            end
        end
    end

    function automatic logic [31:0] make_addr(input int tag, input int index, input int word);
        return {tag[21:0], index[5:0], word[1:0], 2'b00};
    endfunction

    task automatic send_req(input logic r, input logic w, input logic f, input logic [31:0] a,
            input dc_line_t d, input dc_byte_sel_t bs, input logic fd);
        dc_addr_u ua;
        ua.raw = a;
        @(posedge clk);
        i_dc_re          <= r;
        i_dc_we          <= w;
        i_dc_fe          <= f;
        i_dc_addr        <= ua;
        i_dc_data        <= d;
        i_dc_byte_select <= bs;
        i_dc_fill_dirty  <= fd;
        expect_q.push_back(dcache_model_step(w, f, ua, d, bs, fd));
        accept_q.push_back($time + CLK_PERIOD);  // sampled by the DUT at the next edge
    endtask

    task automatic read_word(input logic [31:0] a);
        send_req(1'b1, 1'b0, 1'b0, a, '0, '0, 1'b0);
    endtask

    task automatic store_word(input logic [31:0] a, input dc_data_t v, input dc_byte_sel_t bs);
        send_req(1'b0, 1'b1, 1'b0, a, {96'h0, v}, bs, 1'b0);
    endtask

    task automatic fill_line(input logic [31:0] a, input dc_line_t l, input logic fd);
        send_req(1'b0, 1'b0, 1'b1, a, l, '0, fd);
    endtask

    task automatic go_idle();
        @(posedge clk);
        i_dc_re <= 1'b0;
        i_dc_we <= 1'b0;
        i_dc_fe <= 1'b0;
    endtask

    initial begin
        int          cycles;
        int          kind;
        logic [31:0] a;
        logic [31:0] b;
        i_rst            = 1'b1;
        i_dc_re          = 1'b0;
        i_dc_we          = 1'b0;
        i_dc_fe          = 1'b0;
        i_dc_addr        = '0;
        i_dc_data        = '0;
        i_dc_byte_select = '0;
        i_dc_fill_dirty  = 1'b0;
        void'($urandom(32'h74a63df1));
        for (int i = 0; i < `DC_NUM_LINES; i++) begin
            m_tag[i]   = '0;
            m_line[i]  = '0;
            m_valid[i] = 1'b0;
            m_dirty[i] = 1'b0;
        end
        repeat (5) @(posedge clk);
        i_rst <= 1'b0;

        // empty cache misses everywhere
        read_word(32'h0000_0000);
        read_word(32'h0000_1230);
        read_word(32'hffff_fff0);
        read_word(32'h0000_0044);
        go_idle();

        // clean fill and then every word of the line
        a = make_addr(37, 52, 0);
        b = make_addr(38, 52, 0);
        fill_line(a, 128'h4444_4444_3333_3333_2222_2222_1111_1111, 1'b0);
        for (int w = 0; w < 4; w++) read_word(a + w * 4);
        go_idle();

        // byte merges on a hit and then a store miss to an empty index
        store_word(a + 4, 32'haabb_ccdd, 4'b0101);
        store_word(a + 8, 32'h1122_3344, 4'b1010);
        store_word(a + 12, 32'hdead_beef, 4'b1111);
        store_word(a, 32'h0000_00ee, 4'b0001);
        for (int w = 0; w < 4; w++) read_word(a + w * 4);
        store_word(make_addr(5, 8, 1), 32'hcafe_f00d, 4'b1111);
        read_word(make_addr(5, 8, 1));
        go_idle();

        // victims only for dirty lines of another tag
        fill_line(b, 128'h5555_6666_7777_8888_9999_aaaa_bbbb_cccc, 1'b0);
        fill_line(a, 128'h0101_0202_0303_0404_0505_0606_0707_0808, 1'b0);
        fill_line(a, 128'h1010_2020_3030_4040_5050_6060_7070_8080, 1'b1);
        fill_line(a, 128'h1f1f_2f2f_3f3f_4f4f_5f5f_6f6f_7f7f_8f8f, 1'b0);
        store_word(a + 8, 32'h7777_0000, 4'b1100);
        fill_line(b, 128'hface_face_face_face_face_face_face_face, 1'b1);
        go_idle();

        // one request per cycle with the read right after the store
        store_word(b + 4, 32'h1234_5678, 4'b0110);
        read_word(b + 4);
        read_word(b);
        fill_line(a, 128'hffff_eeee_dddd_cccc_bbbb_aaaa_9999_8888, 1'b1);
        read_word(a + 12);
        go_idle();

        // random traffic over few tags and indexes
        for (int n = 0; n < 400; n++) begin
            kind = $urandom % 3;
            a    = make_addr($urandom % 3, $urandom % 4, $urandom % 4);
            case (kind)
                0: read_word(a);
                1: store_word(a, $urandom, 4'($urandom));
                default: fill_line(a, {$urandom, $urandom, $urandom, $urandom}, 1'($urandom));
            endcase
        end
        go_idle();

        cycles = 0;
        while (expect_q.size() != 0 && cycles < 50) begin
            @(negedge clk);
            cycles++;
        end
        if (expect_q.size() != 0) begin
            $display("Timeout: responses stopped arriving, %0d still outstanding",
                     expect_q.size());
            $display("Some tests failed");
            $fatal(1, "drain timeout");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+source
source/dcache_pkg.sv
source/dcache_req_stage.sv
source/dcache_array_stage.sv
source/dcache.sv
tb/dcache_tb.sv

//--- Makefile
# Verilator build for the data cache

TOP := dcache_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module dcache -f project.f

sim:
	verilator --binary --timing --top-module $(TOP) -f project.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
